// File: credit_counter.sv
`timescale 1ns/1ps

module credit_counter (
	input  logic clk,
	input  logic rst,
	input  logic load_i,
	input  logic en_i,
	output logic done_o
);

	rv_pkg::qcnt_t cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
		end else if (load_i) begin
			cnt <= rv_pkg::qcnt_t'(rv_pkg::QDEPTH);
		end else if (en_i && (cnt != '0)) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign done_o = (cnt == '0);

endmodule

// File: ex_mem.sv
`timescale 1ns/1ps

module ex_mem (
	input  logic          clk,
	input  logic          rst,
	input  logic          issue_i,
	input  rv_pkg::dec_t  dec_i,
	output rv_pkg::fwd_t  ex_fwd_o,
	output rv_pkg::fwd_t  exm_fwd_o,
	output rv_pkg::fwd_t  mem_fwd_o,
	output rv_pkg::wb_t   wb_o
);

	rv_pkg::dec_t       idex_q;
	rv_pkg::word_t      alu_res;
	rv_pkg::word_t      sra_res;
	logic [4:0]         shamt;
	logic               ex_is_op;
	logic               ex_is_store;
	rv_pkg::fwd_t       exm_q;
	logic               exm_store;
	rv_pkg::word_t      exm_sdata;
	rv_pkg::dmem_addr_t dmem_addr;
	rv_pkg::word_t      dmem [rv_pkg::DMEM_WORDS];
	rv_pkg::word_t      ram_q;
	rv_pkg::fwd_t       mwb_q;
	rv_pkg::word_t      wb_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			idex_q.op   <= '0;
			idex_q.wreg <= 1'b0;
		end else if (issue_i) begin
			idex_q <= dec_i;
		end else begin
			idex_q.op   <= '0; // bubble
			idex_q.wreg <= 1'b0;
		end
	end

	assign shamt       = idex_q.b[4:0];
	assign ex_is_op    = (idex_q.op[6:0] == rv_pkg::OPC_OP);
	assign ex_is_store = (idex_q.op[6:0] == rv_pkg::OPC_STORE);
	assign sra_res     = $signed(idex_q.a) >>> shamt; // sign fills from bit 31

	always_comb begin
		case (idex_q.op[6:0])
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: alu_res = idex_q.b; // value built in decode
			rv_pkg::OPC_OP, rv_pkg::OPC_OP_IMM: begin
				case (idex_q.op[9:7])
					3'b000:  alu_res = (ex_is_op && idex_q.op[10]) ? idex_q.a - idex_q.b
					                                               : idex_q.a + idex_q.b;
					3'b001:  alu_res = idex_q.a << shamt;
					3'b010:  alu_res = {31'b0, $signed(idex_q.a) < $signed(idex_q.b)};
					3'b011:  alu_res = {31'b0, idex_q.a < idex_q.b};
					3'b100:  alu_res = idex_q.a ^ idex_q.b;
					3'b101:  alu_res = idex_q.op[10] ? sra_res : idex_q.a >> shamt;
					3'b110:  alu_res = idex_q.a | idex_q.b;
					default: alu_res = idex_q.a & idex_q.b;
				endcase
			end
			default: alu_res = idex_q.a + idex_q.b; // lw/sw address
		endcase
	end

	always_comb begin
		ex_fwd_o.wreg    = idex_q.wreg;
		ex_fwd_o.is_load = (idex_q.op[6:0] == rv_pkg::OPC_LOAD);
		ex_fwd_o.rd      = idex_q.rd;
		ex_fwd_o.data    = alu_res;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			exm_q.wreg    <= 1'b0;
			exm_q.is_load <= 1'b0;
			exm_store     <= 1'b0;
		end else begin
			exm_q     <= ex_fwd_o;
			exm_store <= ex_is_store;
		end
		exm_sdata <= idex_q.store_data;
	end

	assign exm_fwd_o = exm_q;
	assign dmem_addr = exm_q.data[rv_pkg::DMEM_AW+1:2]; // word index

	// synchronous RAM, read data lines up with MEM/WB
	always_ff @(posedge clk) begin
		if (exm_store) begin
			dmem[dmem_addr] <= exm_sdata;
		end
		ram_q <= dmem[dmem_addr];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mwb_q.wreg    <= 1'b0;
			mwb_q.is_load <= 1'b0;
		end else begin
			mwb_q <= exm_q;
		end
	end

	assign wb_data = mwb_q.is_load ? ram_q : mwb_q.data;

	always_comb begin
		mem_fwd_o      = mwb_q;
		mem_fwd_o.data = wb_data;
		wb_o.valid     = mwb_q.wreg; // never set for rd 0
		wb_o.rd        = mwb_q.rd;
		wb_o.data      = wb_data;
	end

endmodule

// File: id.sv
`timescale 1ns/1ps

module id (
	input  rv_pkg::fetch_t    head_i,
	input  logic              valid_i,
	output rv_pkg::reg_addr_t rs1_o,
	output rv_pkg::reg_addr_t rs2_o,
	input  rv_pkg::word_t     rs1_data_i,
	input  rv_pkg::word_t     rs2_data_i,
	input  rv_pkg::fwd_t      ex_fwd_i,
	input  rv_pkg::fwd_t      exm_fwd_i,
	input  rv_pkg::fwd_t      mem_fwd_i,
	output rv_pkg::dec_t      dec_o,
	output logic              stall_o
);

	rv_pkg::inst_t     inst;
	rv_pkg::reg_addr_t rd;
	logic [2:0]        funct3;
	logic [6:0]        funct7;
	rv_pkg::word_t     imm_i;
	rv_pkg::word_t     imm_s;
	rv_pkg::word_t     imm_u;
	rv_pkg::word_t     op1;
	rv_pkg::word_t     op2;
	logic              legal;
	logic              rs1_read;
	logic              rs2_read;

	function automatic logic tap_hit(input rv_pkg::fwd_t tap, input rv_pkg::reg_addr_t addr);
		return tap.wreg && (tap.rd != '0) && (tap.rd == addr);
	endfunction

	// nearest stage wins
	function automatic rv_pkg::word_t fwd_pick(input rv_pkg::reg_addr_t addr,
			input rv_pkg::word_t rf_data, input rv_pkg::fwd_t ex,
			input rv_pkg::fwd_t exm, input rv_pkg::fwd_t mem);
		if (tap_hit(ex, addr)) return ex.data;
		if (tap_hit(exm, addr)) return exm.data;
		if (tap_hit(mem, addr)) return mem.data;
		return rf_data;
	endfunction

	// load data not there yet if the nearest writer is a load in EX or EX/MEM
	function automatic logic load_use(input rv_pkg::reg_addr_t addr,
			input rv_pkg::fwd_t ex, input rv_pkg::fwd_t exm);
		if (tap_hit(ex, addr)) return ex.is_load;
		return tap_hit(exm, addr) && exm.is_load;
	endfunction

	assign inst   = head_i.inst;
	assign rd     = inst[11:7];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign rs1_o  = inst[19:15];
	assign rs2_o  = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	assign op1 = fwd_pick(rs1_o, rs1_data_i, ex_fwd_i, exm_fwd_i, mem_fwd_i);
	assign op2 = fwd_pick(rs2_o, rs2_data_i, ex_fwd_i, exm_fwd_i, mem_fwd_i);

	always_comb begin
		legal    = 1'b0;
		rs1_read = 1'b0;
		rs2_read = 1'b0;
		case (inst[6:0])
			rv_pkg::OPC_OP: begin
				legal    = (funct7 == 7'b0000000) ||
				           ((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));
				rs1_read = legal;
				rs2_read = legal;
			end
			rv_pkg::OPC_OP_IMM: begin
				if (funct3 == 3'b001) begin
					legal = (funct7 == 7'b0000000);
				end else if (funct3 == 3'b101) begin
					legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000); // srli / srai
				end else begin
					legal = 1'b1;
				end
				rs1_read = legal;
			end
			rv_pkg::OPC_LUI, rv_pkg::OPC_AUIPC: legal = 1'b1;
			rv_pkg::OPC_LOAD: begin
				legal    = (funct3 == 3'b010); // word only
				rs1_read = legal;
			end
			rv_pkg::OPC_STORE: begin
				legal    = (funct3 == 3'b010);
				rs1_read = legal;
				rs2_read = legal;
			end
			default: legal = 1'b0;
		endcase
	end

	always_comb begin
		dec_o = '0; // bubble unless legal
		if (legal) begin
			dec_o.op   = {inst[30], funct3, inst[6:0]};
			dec_o.rd   = rd;
			dec_o.wreg = (inst[6:0] != rv_pkg::OPC_STORE) && (rd != '0);
		end
		dec_o.a          = op1;
		dec_o.store_data = op2;
		case (inst[6:0])
			rv_pkg::OPC_OP:    dec_o.b = op2;
			rv_pkg::OPC_LUI:   dec_o.b = imm_u;
			rv_pkg::OPC_AUIPC: dec_o.b = imm_u + head_i.pc;
			rv_pkg::OPC_STORE: dec_o.b = imm_s;
			default:           dec_o.b = imm_i;
		endcase
	end

	assign stall_o = valid_i &&
	                 ((rs1_read && load_use(rs1_o, ex_fwd_i, exm_fwd_i)) ||
	                  (rs2_read && load_use(rs2_o, ex_fwd_i, exm_fwd_i)));

endmodule

// File: inst_queue.sv
`timescale 1ns/1ps

module inst_queue (
	input  logic           clk,
	input  logic           rst,
	input  logic           push_i,
	input  rv_pkg::fetch_t data_i,
	input  logic           pop_i,
	output rv_pkg::fetch_t head_o,
	output logic           empty_o
);

	rv_pkg::fetch_t mem [rv_pkg::QDEPTH];
	rv_pkg::qptr_t  wptr;
	rv_pkg::qptr_t  rptr;
	rv_pkg::qcnt_t  count;
	logic           do_pop;

	assign do_pop  = pop_i && (count != '0); // pop on empty is dropped
	assign empty_o = (count == '0);
	assign head_o  = mem[rptr];

	always_ff @(posedge clk) begin
		if (push_i) begin
			mem[wptr] <= data_i;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			if (push_i) begin
				wptr <= wptr + 1'b1;
			end
			if (do_pop) begin
				rptr <= rptr + 1'b1;
			end
			case ({push_i, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// File: pipe_ctrl.sv
`timescale 1ns/1ps

module pipe_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic empty_i,
	input  logic stall_i,
	input  logic cnt_done_i,
	output logic cnt_load_o,
	output logic cnt_en_o,
	output logic issue_o,
	output logic credit_o
);

	rv_pkg::ctrl_state_t state;
	rv_pkg::ctrl_state_t state_nxt;
	logic                loaded; // counter holds the grant

	always_ff @(posedge clk) begin
		if (rst) begin
			state  <= rv_pkg::INIT;
			loaded <= 1'b0;
		end else begin
			state  <= state_nxt;
			loaded <= 1'b1;
		end
	end

	always_comb begin
		cnt_load_o = 1'b0;
		cnt_en_o   = 1'b0;
		issue_o    = 1'b0;
		state_nxt  = state;
		case (state)
			rv_pkg::INIT: begin
				cnt_load_o = !loaded;
				cnt_en_o   = loaded && !cnt_done_i; // one credit per count
				if (loaded && cnt_done_i) begin
					state_nxt = rv_pkg::RUN;
				end
			end
			default: issue_o = !empty_i && !stall_i;
		endcase
	end

	// each issue frees a queue slot
	assign credit_o = cnt_en_o || issue_o;

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
	input  logic              clk,
	input  logic              rst,
	input  rv_pkg::reg_addr_t rs1_i,
	input  rv_pkg::reg_addr_t rs2_i,
	output rv_pkg::word_t     rs1_data_o,
	output rv_pkg::word_t     rs2_data_o,
	input  rv_pkg::wb_t       wb_i
);

	rv_pkg::word_t regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_i.valid && (wb_i.rd != '0)) begin
			regs[wb_i.rd] <= wb_i.data;
		end
	end

	// x0 reads zero
	assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
	assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f tb.f --top-module tb_rv_core -o tb_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "Testbench failed" sim.log && exit 1 || exit 0

// File: rv_core.sv
`timescale 1ns/1ps

module rv_core (
	input  logic           clk,
	input  logic           rst,
	input  logic           fetch_valid_i,
	input  rv_pkg::fetch_t fetch_i,
	output logic           credit_o,
	output rv_pkg::wb_t    wb_o
);

	rv_pkg::fetch_t    head;
	logic              q_empty;
	logic              issue;
	logic              stall;
	rv_pkg::reg_addr_t rs1;
	rv_pkg::reg_addr_t rs2;
	rv_pkg::word_t     rs1_data;
	rv_pkg::word_t     rs2_data;
	rv_pkg::dec_t      dec;
	rv_pkg::fwd_t      ex_fwd;
	rv_pkg::fwd_t      exm_fwd;
	rv_pkg::fwd_t      mem_fwd;
	logic              cnt_load;
	logic              cnt_en;
	logic              cnt_done;

	inst_queue inst_queue_inst (
		.clk     (clk),
		.rst     (rst),
		.push_i  (fetch_valid_i),
		.data_i  (fetch_i),
		.pop_i   (issue),
		.head_o  (head),
		.empty_o (q_empty)
	);

	id id_inst (
		.head_i     (head),
		.valid_i    (!q_empty),
		.rs1_o      (rs1),
		.rs2_o      (rs2),
		.rs1_data_i (rs1_data),
		.rs2_data_i (rs2_data),
		.ex_fwd_i   (ex_fwd),
		.exm_fwd_i  (exm_fwd),
		.mem_fwd_i  (mem_fwd),
		.dec_o      (dec),
		.stall_o    (stall)
	);

	regfile regfile_inst (
		.clk        (clk),
		.rst        (rst),
		.rs1_i      (rs1),
		.rs2_i      (rs2),
		.rs1_data_o (rs1_data),
		.rs2_data_o (rs2_data),
		.wb_i       (wb_o)
	);

	ex_mem ex_mem_inst (
		.clk       (clk),
		.rst       (rst),
		.issue_i   (issue),
		.dec_i     (dec),
		.ex_fwd_o  (ex_fwd),
		.exm_fwd_o (exm_fwd),
		.mem_fwd_o (mem_fwd),
		.wb_o      (wb_o)
	);

	pipe_ctrl pipe_ctrl_inst (
		.clk        (clk),
		.rst        (rst),
		.empty_i    (q_empty),
		.stall_i    (stall),
		.cnt_done_i (cnt_done),
		.cnt_load_o (cnt_load),
		.cnt_en_o   (cnt_en),
		.issue_o    (issue),
		.credit_o   (credit_o)
	);

	credit_counter credit_counter_inst (
		.clk    (clk),
		.rst    (rst),
		.load_i (cnt_load),
		.en_i   (cnt_en),
		.done_o (cnt_done)
	);

endmodule

// File: rv_pkg.sv
package rv_pkg;

	localparam int XLEN       = 32;
	localparam int QDEPTH     = 4; // queue entries, also the initial credits
	localparam int QPTR_W     = $clog2(QDEPTH);
	localparam int DMEM_WORDS = 64;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;

	typedef logic [XLEN-1:0]    word_t;
	typedef logic [4:0]         reg_addr_t;
	typedef logic [31:0]        inst_t;
	typedef logic [10:0]        op_t;   // {inst[30], funct3, opcode}, zero is a bubble
	typedef logic [QPTR_W-1:0]  qptr_t;
	typedef logic [QPTR_W:0]    qcnt_t; // holds 0..QDEPTH
	typedef logic [DMEM_AW-1:0] dmem_addr_t;

	typedef struct packed {
		inst_t inst;
		word_t pc;
	} fetch_t;

	typedef struct packed {
		op_t       op;
		reg_addr_t rd;
		logic      wreg;
		word_t     a;
		word_t     b;
		word_t     store_data;
	} dec_t;

	// one forwarding tap from a later stage
	typedef struct packed {
		logic      wreg;
		logic      is_load;
		reg_addr_t rd;
		word_t     data;
	} fwd_t;

	typedef struct packed {
		logic      valid;
		reg_addr_t rd;
		word_t     data;
	} wb_t;

	typedef enum logic {
		INIT,
		RUN
	} ctrl_state_t;

endpackage

// File: tb.f
rv_pkg.sv
inst_queue.sv
id.sv
regfile.sv
ex_mem.sv
pipe_ctrl.sv
credit_counter.sv
rv_core.sv
tb_rv_core_sva.sv
tb_rv_core.sv

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

	localparam int N_INSTS     = 241; // directed plus random
	localparam int CYCLE_LIMIT = N_INSTS * 4 + 200;

	logic           clk;
	logic           rst;
	logic           fetch_valid_i;
	rv_pkg::fetch_t fetch_i;
	logic           credit_o;
	rv_pkg::wb_t    wb_o;

	int            credits;
	int            errors;
	int            cycles;
	rv_pkg::word_t pc;
	rv_pkg::word_t arch [32];
	rv_pkg::word_t mem [rv_pkg::DMEM_WORDS];
	bit            written [rv_pkg::DMEM_WORDS];
	rv_pkg::wb_t   exp_q [$];

	rv_core rv_core_inst (
		.clk           (clk),
		.rst           (rst),
		.fetch_valid_i (fetch_valid_i),
		.fetch_i       (fetch_i),
		.credit_o      (credit_o),
		.wb_o          (wb_o)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic rv_pkg::inst_t enc_r(input logic [6:0] f7, input int rs2, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] opc);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic rv_pkg::inst_t enc_i(input logic [11:0] imm, input int rs1,
			input logic [2:0] f3, input int rd, input logic [6:0] opc);
		return {imm, 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic rv_pkg::inst_t enc_sw(input logic [11:0] imm, input int rs2, input int rs1);
		return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::OPC_STORE};
	endfunction

	function automatic rv_pkg::word_t alu(input logic [2:0] f3, input logic alt,
			input rv_pkg::word_t a, input rv_pkg::word_t b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 1 : 0;
			3'd3: return (a < b) ? 1 : 0;
			3'd4: return a ^ b;
			3'd5: return alt ? rv_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	// architectural effect of one instruction, in program order
	function automatic void run_model(input rv_pkg::inst_t in, input rv_pkg::word_t ipc);
		logic [2:0]    f3;
		logic [6:0]    f7;
		rv_pkg::word_t a;
		rv_pkg::word_t b;
		rv_pkg::word_t imm;
		rv_pkg::word_t res;
		logic          wr;
		f3  = in[14:12];
		f7  = in[31:25];
		a   = arch[in[19:15]];
		b   = arch[in[24:20]];
		imm = {{20{in[31]}}, in[31:20]};
		wr  = 1'b0;
		res = '0;
		case (in[6:0])
			rv_pkg::OPC_OP: begin
				wr  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
				res = alu(f3, f7[5], a, b);
			end
			rv_pkg::OPC_OP_IMM: begin
				wr = (f3 == 3'd1) ? (f7 == 7'h00) :
				     (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
				res = alu(f3, (f3 == 3'd5) && in[30], a, imm);
			end
			rv_pkg::OPC_LUI: begin
				wr  = 1'b1;
				res = {in[31:12], 12'b0};
			end
			rv_pkg::OPC_AUIPC: begin
				wr  = 1'b1;
				res = {in[31:12], 12'b0} + ipc;
			end
			rv_pkg::OPC_LOAD: begin
				wr  = (f3 == 3'd2);
				res = mem[6'((a + imm) >> 2)];
			end
			rv_pkg::OPC_STORE: begin
				if (f3 == 3'd2) begin
					imm = {{20{in[31]}}, in[31:25], in[11:7]};
					mem[6'((a + imm) >> 2)] = b;
					written[6'((a + imm) >> 2)] = 1'b1;
				end
			end
			default: wr = 1'b0; // bubble
		endcase
		if (wr && in[11:7] != 5'd0) begin
			arch[in[11:7]] = res;
			exp_q.push_back('{valid: 1'b1, rd: in[11:7], data: res});
		end
	endfunction

	// credit-limited source
	task automatic send(input rv_pkg::inst_t in);
		while (credits == 0) @(negedge clk);
		fetch_valid_i = 1'b1;
		fetch_i       = '{inst: in, pc: pc};
		run_model(in, pc);
		pc = pc + 4;
		@(negedge clk);
		fetch_valid_i = 1'b0;
	endtask

	always @(posedge clk) begin
		if (!rst) begin
			credits = credits + int'(credit_o) - int'(fetch_valid_i);
			assert (credits >= 0 && credits <= rv_pkg::QDEPTH) else begin
				errors++;
				$display("source credit count out of range: %0d", credits);
			end
		end
	end

	// writeback monitor, mid-cycle
	always @(negedge clk) begin
		rv_pkg::wb_t e;
		if (!rst && wb_o.valid) begin
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("unexpected writeback to x%0d at %0t", wb_o.rd, $time);
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (wb_o.rd == e.rd) else begin
					errors++;
					$display("mismatch at %0t: wb_o.rd exp %0d got %0d", $time, e.rd, wb_o.rd);
				end
				assert (wb_o.data == e.data) else begin
					errors++;
					$display("mismatch at %0t: wb_o.data exp %h got %h", $time, e.data, wb_o.data);
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, errors %0d", cycles, errors);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic test_credits();
		repeat (rv_pkg::QDEPTH + 4) @(negedge clk);
		assert (credits == rv_pkg::QDEPTH) else begin
			errors++;
			$display("mismatch at %0t: initial credits exp %0d got %0d", $time,
				rv_pkg::QDEPTH, credits);
		end
	endtask

	task automatic test_arith();
		send(enc_i(12'h123, 0, 3'd0, 1, rv_pkg::OPC_OP_IMM));
		send(enc_i(12'hf85, 0, 3'd0, 2, rv_pkg::OPC_OP_IMM)); // negative
		for (int f = 0; f < 8; f++) begin
			send(enc_r(7'h00, 2, 1, 3'(f), 3 + f, rv_pkg::OPC_OP));
			send(enc_i((f == 1 || f == 5) ? 12'h007 : 12'h9a3, 2, 3'(f), 11 + f,
				rv_pkg::OPC_OP_IMM));
		end
		send(enc_r(7'h20, 2, 1, 3'd0, 20, rv_pkg::OPC_OP));  // sub
		send(enc_r(7'h20, 1, 2, 3'd5, 21, rv_pkg::OPC_OP));  // sra
		send(enc_i(12'h403, 2, 3'd5, 22, rv_pkg::OPC_OP_IMM)); // srai
	endtask

	task automatic test_upper();
		rv_pkg::word_t pcs [3] = '{32'h0000_1000, 32'h8000_0ffc, 32'hffff_fff0};
		send({20'habcde, 5'd5, rv_pkg::OPC_LUI});
		for (int i = 0; i < 3; i++) begin
			pc = pcs[i];
			send({20'h12345 + 20'(i), 5'd6 + 5'(i), rv_pkg::OPC_AUIPC});
		end
	endtask

	task automatic test_forward();
		send(enc_i(12'h005, 0, 3'd0, 1, rv_pkg::OPC_OP_IMM));
		send(enc_i(12'h003, 1, 3'd0, 1, rv_pkg::OPC_OP_IMM)); // distance 1, same rd
		send(enc_r(7'h00, 1, 1, 3'd0, 2, rv_pkg::OPC_OP));
		send(enc_i(12'h001, 0, 3'd0, 9, rv_pkg::OPC_OP_IMM));
		send(enc_r(7'h00, 2, 1, 3'd4, 3, rv_pkg::OPC_OP));    // distance 2
		send(enc_i(12'h001, 0, 3'd0, 9, rv_pkg::OPC_OP_IMM));
		send(enc_i(12'h001, 0, 3'd0, 10, rv_pkg::OPC_OP_IMM));
		send(enc_r(7'h00, 3, 2, 3'd0, 4, rv_pkg::OPC_OP));    // distance 3
	endtask

	task automatic test_mem();
		send(enc_i(12'h040, 0, 3'd0, 7, rv_pkg::OPC_OP_IMM));
		send(enc_sw(12'h008, 4, 7));
		send(enc_sw(12'h00c, 1, 7));
		send(enc_i(12'h008, 7, 3'd2, 8, rv_pkg::OPC_LOAD));
		send(enc_r(7'h00, 8, 8, 3'd0, 9, rv_pkg::OPC_OP));    // load-use
		send(enc_i(12'h00c, 7, 3'd2, 10, rv_pkg::OPC_LOAD));
		send(enc_i(12'h001, 0, 3'd0, 11, rv_pkg::OPC_OP_IMM));
		send(enc_r(7'h00, 10, 9, 3'd0, 12, rv_pkg::OPC_OP));  // load two back
	endtask

	task automatic test_random();
		rv_pkg::inst_t in;
		int            idx;
		for (int n = 0; n < 200; n++) begin
			idx = $urandom_range(0, rv_pkg::DMEM_WORDS - 1);
			case ($urandom_range(0, 7))
				0: in = enc_r(($urandom_range(0, 1) != 0) ? 7'h20 : 7'h00, $urandom_range(0, 7),
					$urandom_range(0, 7), 3'($urandom_range(0, 7)), $urandom_range(0, 7),
					rv_pkg::OPC_OP);
				1, 2: in = enc_i(12'($urandom()), $urandom_range(0, 7), 3'($urandom_range(0, 7)),
					$urandom_range(0, 7), rv_pkg::OPC_OP_IMM);
				3: in = {20'($urandom()), 5'($urandom_range(0, 7)),
					($urandom_range(0, 1) != 0) ? rv_pkg::OPC_LUI : rv_pkg::OPC_AUIPC};
				4: in = enc_sw(12'(idx * 4), $urandom_range(0, 7), 0);
				5: begin
					if (!written[idx]) idx = 0;
					if (!written[idx]) in = enc_sw(12'(idx * 4), $urandom_range(0, 7), 0);
					else in = enc_i(12'(idx * 4), 0, 3'd2, $urandom_range(0, 7), rv_pkg::OPC_LOAD);
				end
				6: in = {25'($urandom()), 7'b1100011}; // branch
				default: in = enc_i(12'h000, 0, 3'd0, $urandom_range(1, 7), 7'b0000011); // lb
			endcase
			send(in);
			repeat ($urandom_range(0, 2)) @(negedge clk);
		end
	endtask

	// wait for the pipe to empty, then report what never came out
	task automatic drain_writebacks();
		int waited;
		waited = 0;
		while (exp_q.size() != 0 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		assert (exp_q.size() == 0) else begin
			errors++;
			$display("%0d expected writebacks never arrived", exp_q.size());
		end
	endtask

	initial begin
		void'($urandom(75647));
		errors        = 0;
		cycles        = 0;
		credits       = 0;
		pc            = 32'h0000_0100;
		fetch_valid_i = 1'b0;
		fetch_i       = '0;
		for (int i = 0; i < 32; i++) arch[i] = '0;
		for (int i = 0; i < rv_pkg::DMEM_WORDS; i++) begin
			mem[i]     = '0;
			written[i] = 1'b0;
		end
		rst = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		test_credits();
		test_arith();
		test_upper();
		test_forward();
		test_mem();
		test_random();
		drain_writebacks();
		repeat (10) @(negedge clk); // catch stray writebacks
		assert (credits == rv_pkg::QDEPTH) else begin
			errors++;
			$display("not every sent instruction was credited back, credits %0d", credits);
		end
		$display("errors: %0d, assertion failures: %0d, missing writebacks: %0d", errors,
			rv_core_inst.sva_inst.fails, exp_q.size());
		if (errors == 0 && rv_core_inst.sva_inst.fails == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: tb_rv_core_sva.sv
`timescale 1ns/1ps

module tb_rv_core_sva (
	input logic         clk,
	input logic         rst,
	input logic         fetch_valid_i,
	input logic         issue,
	input logic         stall,
	input logic         q_empty,
	input logic         credit_o,
	input rv_pkg::fwd_t ex_fwd,
	input rv_pkg::wb_t  wb_o
);

	int  occ; // queue occupancy seen from the ports
	logic full;
	int  fails;

	assign full = (occ == rv_pkg::QDEPTH);

	always @(posedge clk) begin
		if (rst) begin
			occ <= 0;
		end else begin
			occ <= occ + int'(fetch_valid_i) - int'(issue && !q_empty);
		end
	end

	a_no_push_full: assert property (@(posedge clk) disable iff (rst) !(fetch_valid_i && full))
		else begin
			fails++;
			$error("queue pushed while full");
		end
	a_no_credit_full: assert property (@(posedge clk) disable iff (rst)
		!(credit_o && full && !issue))
		else begin
			fails++;
			$error("credit returned while queue full and not issuing");
		end
	a_no_wb_x0: assert property (@(posedge clk) disable iff (rst) wb_o.valid |-> (wb_o.rd != '0))
		else begin
			fails++;
			$error("writeback reported for x0");
		end
	// a stalled head must leave a bubble in EX
	a_stall_bubble: assert property (@(posedge clk) disable iff (rst)
		stall |=> !(ex_fwd.wreg || ex_fwd.is_load))
		else begin
			fails++;
			$error("instruction entered execute during a stall");
		end

endmodule

bind rv_core tb_rv_core_sva sva_inst (
	.clk           (clk),
	.rst           (rst),
	.fetch_valid_i (fetch_valid_i),
	.issue         (issue),
	.stall         (stall),
	.q_empty       (q_empty),
	.credit_o      (credit_o),
	.ex_fwd        (ex_fwd),
	.wb_o          (wb_o)
);
